//--- hw/tx_frame_pkg.sv
package tx_frame_pkg;

	// Field widths of the command format
	localparam int ADDR_W = 16;
	localparam int LEN_W = 16;

	// Opcode byte, bits [31:24] of descriptor word 2
	typedef enum logic [7:0] {
		OP_SEGMENT      = 8'h00,
		OP_LAST_SEGMENT = 8'h01
	} desc_op_e;

	// Next expected command word
	typedef enum logic [1:0] {
		CW_LEN_ADDR,
		CW_DW2,
		CW_DW3
	} cmd_word_e;

	typedef struct packed {
		logic              last;
		logic [LEN_W-1:0]  len;
		logic [ADDR_W-1:0] addr;
	} tx_desc_t;

	// Length in the upper half, address in the lower half
	typedef struct packed {
		logic [LEN_W-1:0]  len;
		logic [ADDR_W-1:0] addr;
	} tx_status_t;

	typedef struct packed {
		logic [3:0]        id;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
	} dram_ar_t;

	typedef struct packed {
		logic [3:0]  id;
		logic [31:0] data;
		logic [1:0]  resp;
		logic        last;
	} dram_r_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  keep;
		logic        last;
	} mac_beat_t;

endpackage

//--- hw/tx_desc_parser.sv
module tx_desc_parser
	import tx_frame_pkg::*;
#(
	parameter int QUEUE_DEPTH = 16
) (
	input  logic        aclk,
	input  logic        aresetn,
	input  logic [31:0] cmd_s_tdata,
	input  logic        cmd_s_tvalid,
	input  logic        cmd_s_tlast,
	output logic        cmd_s_tready,
	output logic        push,
	output tx_desc_t    push_desc,
	input  logic        credit_return
);

	localparam int CRED_W = $clog2(QUEUE_DEPTH + 1);

	cmd_word_e         cmd_word;
	logic [LEN_W-1:0]  seg_len;
	logic [ADDR_W-1:0] seg_addr;
	desc_op_e          seg_op;
	logic [31:0]       desc_dw3;
	logic [CRED_W-1:0] credits;
	logic              beat;
	desc_op_e          beat_op;

	assign beat = cmd_s_tvalid && cmd_s_tready;
	assign beat_op = desc_op_e'(cmd_s_tdata[31:24]);
	assign cmd_s_tready = (credits != '0);
	assign push = beat && cmd_s_tlast;

	// Short commands end early, so fields of the current beat bypass the registers
	always_comb begin
		push_desc.len = seg_len;
		push_desc.addr = seg_addr;
		push_desc.last = (seg_op == OP_LAST_SEGMENT);
		case (cmd_word)
			CW_LEN_ADDR: begin
				push_desc.len = cmd_s_tdata[31:16];
				push_desc.addr = cmd_s_tdata[15:0];
				push_desc.last = 1'b0;
			end
			CW_DW2: begin
				push_desc.last = (beat_op == OP_LAST_SEGMENT);
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			cmd_word <= CW_LEN_ADDR;
		end else if (beat) begin
			if (cmd_s_tlast) begin
				cmd_word <= CW_LEN_ADDR;
			end else if (cmd_word == CW_LEN_ADDR) begin
				cmd_word <= CW_DW2;
			end else begin
				cmd_word <= CW_DW3;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (beat) begin
			case (cmd_word)
				CW_LEN_ADDR: begin
					seg_len <= cmd_s_tdata[31:16];
					seg_addr <= cmd_s_tdata[15:0];
					seg_op <= OP_SEGMENT;
				end
				CW_DW2: begin
					seg_op <= beat_op;
				end
				default: begin
					desc_dw3 <= cmd_s_tdata;
				end
			endcase
		end
	end

	// One credit per free queue slot
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			credits <= CRED_W'(QUEUE_DEPTH);
		end else if (credit_return && !push) begin
			credits <= credits + 1'b1;
		end else if (push && !credit_return) begin
			credits <= credits - 1'b1;
		end
	end

endmodule

//--- hw/tx_desc_queue.sv
module tx_desc_queue
	import tx_frame_pkg::*;
#(
	parameter int QUEUE_DEPTH = 16
) (
	input  logic     aclk,
	input  logic     aresetn,
	input  logic     push,
	input  tx_desc_t push_desc,
	output logic     desc_valid,
	output tx_desc_t head_desc,
	input  logic     desc_ready,
	output logic     credit_return
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	tx_desc_t         mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] frames;
	logic             full;
	logic             pop;
	logic             push_last;
	logic             pop_last;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	// First word falls through
	assign head_desc = mem[rd_ptr];
	assign full = (count == CNT_W'(QUEUE_DEPTH));

	// Release once a whole frame is queued, or when nothing more fits
	assign desc_valid = (frames != '0) || full;
	assign pop = desc_valid && desc_ready;
	assign credit_return = pop;

	assign push_last = push && push_desc.last;
	assign pop_last = pop && head_desc.last;

	always_ff @(posedge aclk) begin
		if (push) begin
			mem[wr_ptr] <= push_desc;
		end
	end

	// No full check, the parser credits keep pushes within depth
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Complete frames held
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			frames <= '0;
		end else if (push_last && !pop_last) begin
			frames <= frames + 1'b1;
		end else if (pop_last && !push_last) begin
			frames <= frames - 1'b1;
		end
	end

endmodule

//--- hw/tx_dma_reader.sv
module tx_dma_reader
	import tx_frame_pkg::*;
#(
	parameter int MAX_BURST = 16
) (
	input  logic       aclk,
	input  logic       aresetn,
	input  logic       desc_valid,
	input  tx_desc_t   head_desc,
	output logic       desc_ready,
	output dram_ar_t   dram_m_ar,
	output logic       dram_m_arvalid,
	input  logic       dram_m_arready,
	input  dram_r_t    dram_m_r,
	input  logic       dram_m_rvalid,
	output logic       dram_m_rready,
	output mac_beat_t  mac_m,
	output logic       mac_m_tvalid,
	input  logic       mac_m_tready,
	output tx_status_t stat_m_tdata,
	output logic       stat_m_tvalid,
	output logic       stat_m_tlast,
	input  logic       stat_m_tready
);

	localparam logic [2:0] AXI_SIZE_4B = 3'b010;
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;
	localparam int BURST_W = $clog2(MAX_BURST + 1);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA,
		RD_STAT
	} rd_state_e;

	rd_state_e          state;
	logic [ADDR_W-1:0]  cur_addr;
	logic [LEN_W-1:0]   words_left;
	logic [BURST_W-1:0] burst_left;
	logic [LEN_W-1:0]   burst_words;
	logic [LEN_W-1:0]   head_words;
	logic [3:0]         tail_keep;
	logic               seg_last;
	logic               pop;
	logic               r_beat;
	logic               final_beat;

	assign desc_ready = (state == RD_IDLE);
	assign pop = desc_valid && desc_ready;

	// Segment length rounded up to whole words
	assign head_words = LEN_W'(({1'b0, head_desc.len} + (LEN_W + 1)'(3)) >> 2);
	assign burst_words = (words_left > LEN_W'(MAX_BURST)) ? LEN_W'(MAX_BURST) : words_left;

	always_comb begin
		dram_m_ar.id = '0;
		dram_m_ar.addr = cur_addr;
		dram_m_ar.len = 8'(burst_words - 1'b1);
		dram_m_ar.size = AXI_SIZE_4B;
		dram_m_ar.burst = AXI_BURST_INCR;
	end
	assign dram_m_arvalid = (state == RD_ADDR);

	// R beats go straight through, MAC back-pressure stalls the read
	assign dram_m_rready = (state == RD_DATA) && mac_m_tready;
	assign mac_m_tvalid = (state == RD_DATA) && dram_m_rvalid;
	assign r_beat = dram_m_rvalid && dram_m_rready;
	assign final_beat = (words_left == LEN_W'(1));

	always_comb begin
		mac_m.data = dram_m_r.data;
		mac_m.keep = final_beat ? tail_keep : 4'hf;
		mac_m.last = final_beat && seg_last;
	end

	assign stat_m_tvalid = (state == RD_STAT);
	assign stat_m_tlast = 1'b1;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= RD_IDLE;
			words_left <= '0;
			burst_left <= '0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (pop) begin
						words_left <= head_words;
						state <= (head_words == '0) ? RD_STAT : RD_ADDR;
					end
				end
				RD_ADDR: begin
					if (dram_m_arready) begin
						burst_left <= BURST_W'(burst_words);
						state <= RD_DATA;
					end
				end
				RD_DATA: begin
					if (r_beat) begin
						words_left <= words_left - 1'b1;
						burst_left <= burst_left - 1'b1;
						if (final_beat) begin
							state <= RD_STAT;
						end else if (burst_left == BURST_W'(1)) begin
							state <= RD_ADDR;
						end
					end
				end
				default: begin
					if (stat_m_tready) begin
						state <= RD_IDLE;
					end
				end
			endcase
		end
	end

	// Low address bits dropped, buffers are word aligned
	always_ff @(posedge aclk) begin
		if (pop) begin
			cur_addr <= {head_desc.addr[ADDR_W-1:2], 2'b00};
			seg_last <= head_desc.last;
			stat_m_tdata <= '{len: head_desc.len, addr: head_desc.addr};
			case (head_desc.len[1:0])
				2'd1: tail_keep <= 4'b0001;
				2'd2: tail_keep <= 4'b0011;
				2'd3: tail_keep <= 4'b0111;
				default: tail_keep <= 4'b1111;
			endcase
		end else if (r_beat) begin
			cur_addr <= cur_addr + ADDR_W'(4);
		end
	end

endmodule

//--- hw/tx_frame.sv
module tx_frame
	import tx_frame_pkg::*;
#(
	parameter int QUEUE_DEPTH = 16,
	parameter int MAX_BURST = 16
) (
	input  logic        aclk,
	input  logic        aresetn,

	// Command words: len/addr, DW2 with opcode, DW3
	input  logic [31:0] cmd_s_tdata,
	input  logic        cmd_s_tvalid,
	input  logic        cmd_s_tlast,
	output logic        cmd_s_tready,

	// One status word per segment
	output tx_status_t  stat_m_tdata,
	output logic        stat_m_tvalid,
	output logic        stat_m_tlast,
	input  logic        stat_m_tready,

	// DRAM read channels
	output dram_ar_t    dram_m_ar,
	output logic        dram_m_arvalid,
	input  logic        dram_m_arready,
	input  dram_r_t     dram_m_r,
	input  logic        dram_m_rvalid,
	output logic        dram_m_rready,

	// MAC transmit stream
	output mac_beat_t   mac_m,
	output logic        mac_m_tvalid,
	input  logic        mac_m_tready
);

	logic     push;
	tx_desc_t push_desc;
	logic     credit_return;
	logic     desc_valid;
	logic     desc_ready;
	tx_desc_t head_desc;

	tx_desc_parser #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) parser0 (
		.aclk(aclk),
		.aresetn(aresetn),
		.cmd_s_tdata(cmd_s_tdata),
		.cmd_s_tvalid(cmd_s_tvalid),
		.cmd_s_tlast(cmd_s_tlast),
		.cmd_s_tready(cmd_s_tready),
		.push(push),
		.push_desc(push_desc),
		.credit_return(credit_return)
	);

	tx_desc_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) queue0 (
		.aclk(aclk),
		.aresetn(aresetn),
		.push(push),
		.push_desc(push_desc),
		.desc_valid(desc_valid),
		.head_desc(head_desc),
		.desc_ready(desc_ready),
		.credit_return(credit_return)
	);

	tx_dma_reader #(
		.MAX_BURST(MAX_BURST)
	) reader0 (
		.aclk(aclk),
		.aresetn(aresetn),
		.desc_valid(desc_valid),
		.head_desc(head_desc),
		.desc_ready(desc_ready),
		.dram_m_ar(dram_m_ar),
		.dram_m_arvalid(dram_m_arvalid),
		.dram_m_arready(dram_m_arready),
		.dram_m_r(dram_m_r),
		.dram_m_rvalid(dram_m_rvalid),
		.dram_m_rready(dram_m_rready),
		.mac_m(mac_m),
		.mac_m_tvalid(mac_m_tvalid),
		.mac_m_tready(mac_m_tready),
		.stat_m_tdata(stat_m_tdata),
		.stat_m_tvalid(stat_m_tvalid),
		.stat_m_tlast(stat_m_tlast),
		.stat_m_tready(stat_m_tready)
	);

endmodule

//--- bench/tx_frame_tests.svh
task automatic send_word(input logic [31:0] data, input logic tl);
	cmd_s_tdata = data;
	cmd_s_tvalid = 1'b1;
	cmd_s_tlast = tl;
	do begin
		@(posedge aclk);
	end while (!cmd_s_tready);
	#1;
	cmd_s_tvalid = 1'b0;
	cmd_s_tlast = 1'b0;
endtask

// Expected MAC beats, AR requests and status word of one segment
task automatic expect_segment(input int len, input logic [ADDR_W-1:0] addr, input logic last);
	mac_beat_t         beat;
	dram_ar_t          ar;
	tx_status_t        stat;
	int                words;
	int                left;
	int                n;
	logic [ADDR_W-1:0] a;
	words = (len + 3) / 4;
	a = {addr[ADDR_W-1:2], 2'b00};
	for (int w = 0; w < words; w++) begin
		beat.data = model_word(a + ADDR_W'(4 * w));
		beat.keep = 4'hf;
		beat.last = 1'b0;
		if (w == words - 1) begin
			case (len % 4)
				1: beat.keep = 4'b0001;
				2: beat.keep = 4'b0011;
				3: beat.keep = 4'b0111;
				default: beat.keep = 4'b1111;
			endcase
			beat.last = last;
		end
		exp_beats.push_back(beat);
	end
	left = words;
	while (left > 0) begin
		n = (left > MAX_BURST) ? MAX_BURST : left;
		ar.id = '0;
		ar.addr = a;
		ar.len = 8'(n - 1);
		ar.size = 3'b010;
		ar.burst = 2'b01;
		exp_ars.push_back(ar);
		a = a + ADDR_W'(4 * n);
		left = left - n;
	end
	stat.len = LEN_W'(len);
	stat.addr = addr;
	exp_stats.push_back(stat);
endtask

task automatic push_segment(input int len, input logic [ADDR_W-1:0] addr, input logic last);
	logic [7:0] op;
	op = last ? OP_LAST_SEGMENT : OP_SEGMENT;
	expect_segment(len, addr, last);
	send_word({LEN_W'(len), addr}, 1'b0);
	send_word({op, 24'h0}, 1'b0);
	send_word({16'hc0de, addr}, 1'b1);
	descs_sent++;
endtask

task automatic wait_status(input int n);
	do begin
		@(posedge aclk);
		#1;
	end while (got_stats.size() < n);
endtask

task automatic compare_all(input string name);
	if (got_beats.size() != exp_beats.size() || got_stats.size() != exp_stats.size() ||
		ar_log.size() != exp_ars.size()) begin
		errors++;
		$display("Mismatch at %0t: %s counts got %0d/%0d/%0d, expected %0d/%0d/%0d", $time,
			name, got_beats.size(), got_stats.size(), ar_log.size(),
			exp_beats.size(), exp_stats.size(), exp_ars.size());
	end
	for (int i = 0; i < got_beats.size() && i < exp_beats.size(); i++) begin
		check_beat(got_beats[i], exp_beats[i], $sformatf("%s beat %0d", name, i));
	end
	for (int i = 0; i < got_stats.size() && i < exp_stats.size(); i++) begin
		check_status(got_stats[i], exp_stats[i], $sformatf("%s status %0d", name, i));
	end
	for (int i = 0; i < ar_log.size() && i < exp_ars.size(); i++) begin
		check_ar(ar_log[i], exp_ars[i], $sformatf("%s AR %0d", name, i));
	end
	got_beats.delete();
	exp_beats.delete();
	got_stats.delete();
	exp_stats.delete();
	ar_log.delete();
	exp_ars.delete();
endtask

task automatic verify_reset_values();
	if (!cmd_s_tready || dram_m_arvalid || dram_m_rready || mac_m_tvalid || stat_m_tvalid) begin
		errors++;
		$display("Error: outputs after reset are not in their idle state");
	end
endtask

task automatic single_segment_frame();
	push_segment(10, 16'h0100, 1'b1);
	wait_status(1);
	compare_all("single segment");
endtask

task automatic three_segment_frame();
	push_segment(8, 16'h0200, 1'b0);
	push_segment(40, 16'h0300, 1'b0);
	push_segment(6, 16'h0400, 1'b1);
	wait_status(3);
	compare_all("three segments");
endtask

task automatic frame_gating();
	push_segment(12, 16'h0500, 1'b0);
	push_segment(20, 16'h0600, 1'b0);
	repeat (50) @(posedge aclk);
	#1;
	if (got_beats.size() != 0 || ar_log.size() != 0) begin
		errors++;
		$display("Error: reads started before the frame was complete");
	end
	push_segment(7, 16'h0700, 1'b1);
	wait_status(3);
	compare_all("frame gating");
endtask

// A full queue releases only its head segment until the last segment arrives
task automatic queue_full_release();
	push_segment(16, 16'h0800, 1'b0);
	push_segment(4, 16'h0900, 1'b0);
	push_segment(24, 16'h0a00, 1'b0);
	push_segment(9, 16'h0b00, 1'b0);
	wait_status(1);
	push_segment(5, 16'h0c00, 1'b1);
	wait_status(5);
	compare_all("queue full");
endtask

task automatic mac_back_pressure();
	ready_mode = READY_RANDOM;
	push_segment(8, 16'h0200, 1'b0);
	push_segment(40, 16'h0300, 1'b0);
	push_segment(6, 16'h0400, 1'b1);
	wait_status(3);
	ready_mode = READY_ALL;
	compare_all("back pressure");
endtask

task automatic credit_limit();
	int start;
	start = descs_sent;
	ready_mode = MAC_HELD;
	fork
		begin
			for (int i = 0; i < 10; i++) begin
				push_segment(4 + 3 * i, ADDR_W'(32'h1000 + 32'h40 * i), 1'b1);
			end
		end
		begin
			repeat (100) @(posedge aclk);
			#1;
			if (cmd_s_tready || descs_sent >= start + 10) begin
				errors++;
				$display("Error: command stream was not stalled when credits ran out");
			end
			ready_mode = READY_ALL;
		end
	join
	wait_status(10);
	compare_all("credits");
endtask

//--- bench/tx_frame_tb.sv
module tx_frame_tb
	import tx_frame_pkg::*;
();

	localparam int QUEUE_DEPTH = 4;
	localparam int MAX_BURST = 4;
	// Descriptors sent over all tests
	localparam int NUM_DESCS = 25;
	localparam int WATCHDOG_CYCLES = 200 * NUM_DESCS + 2000;
	localparam int READY_ALL = 0;
	localparam int READY_RANDOM = 1;
	localparam int MAC_HELD = 2;

	logic        aclk;
	logic        aresetn;
	logic [31:0] cmd_s_tdata;
	logic        cmd_s_tvalid;
	logic        cmd_s_tlast;
	logic        cmd_s_tready;
	tx_status_t  stat_m_tdata;
	logic        stat_m_tvalid;
	logic        stat_m_tlast;
	logic        stat_m_tready;
	dram_ar_t    dram_m_ar;
	logic        dram_m_arvalid;
	logic        dram_m_arready;
	dram_r_t     dram_m_r;
	logic        dram_m_rvalid;
	logic        dram_m_rready;
	mac_beat_t   mac_m;
	logic        mac_m_tvalid;
	logic        mac_m_tready;

	integer      seed;
	logic [31:0] rnd;
	int          errors;
	int          ready_mode;
	int          descs_sent;
	int          beat_idx;
	mac_beat_t   exp_beats[$];
	mac_beat_t   got_beats[$];
	tx_status_t  exp_stats[$];
	tx_status_t  got_stats[$];
	dram_ar_t    exp_ars[$];
	dram_ar_t    ar_log[$];
	dram_ar_t    pend_ars[$];

	tx_frame #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.MAX_BURST(MAX_BURST)
	) dut0 (.*);

	initial aclk = 1'b0;
	always #5 aclk = ~aclk;

	// Byte at address a is a[7:0] ^ 8'h5a
	function automatic logic [31:0] model_word(input logic [ADDR_W-1:0] addr);
		logic [31:0]       w;
		logic [ADDR_W-1:0] a;
		for (int k = 0; k < 4; k++) begin
			a = addr + ADDR_W'(k);
			w[8*k +: 8] = a[7:0] ^ 8'h5a;
		end
		return w;
	endfunction

	// DRAM read model serving one burst at a time in AR order
	always @(posedge aclk) begin
		if (dram_m_rvalid && dram_m_rready) begin
			if (beat_idx == int'(pend_ars[0].len)) begin
				pend_ars.delete(0);
				beat_idx = 0;
			end else begin
				beat_idx++;
			end
		end
		if (dram_m_arvalid && dram_m_arready) begin
			ar_log.push_back(dram_m_ar);
			pend_ars.push_back(dram_m_ar);
		end
		#1;
		if (pend_ars.size() != 0) begin
			dram_m_rvalid = 1'b1;
			dram_m_r.id = pend_ars[0].id;
			dram_m_r.data = model_word(pend_ars[0].addr + ADDR_W'(4 * beat_idx));
			dram_m_r.resp = 2'b00;
			dram_m_r.last = (beat_idx == int'(pend_ars[0].len));
		end else begin
			dram_m_rvalid = 1'b0;
			dram_m_r = '0;
		end
	end

	// Sink ready patterns
	always @(posedge aclk) begin
		#1;
		case (ready_mode)
			READY_RANDOM: begin
				rnd = $random(seed);
				mac_m_tready = rnd[0];
				rnd = $random(seed);
				stat_m_tready = rnd[0];
			end
			MAC_HELD: begin
				mac_m_tready = 1'b0;
				stat_m_tready = 1'b1;
			end
			default: begin
				mac_m_tready = 1'b1;
				stat_m_tready = 1'b1;
			end
		endcase
	end

	always @(posedge aclk) begin
		if (mac_m_tvalid && mac_m_tready) begin
			got_beats.push_back(mac_m);
		end
		if (stat_m_tvalid && stat_m_tready) begin
			got_stats.push_back(stat_m_tdata);
			if (!stat_m_tlast) begin
				errors++;
				$display("Error: status word at %0t was sent without tlast", $time);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge aclk);
		$display("Error: run timed out, the DUT stopped delivering data or status");
		$display("Checks failed");
		$finish;
	end

	task automatic check_beat(input mac_beat_t got, input mac_beat_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got data %h keep %b last %b, expected %h %b %b",
				$time, what, got.data, got.keep, got.last, exp.data, exp.keep, exp.last);
		end
	endtask

	task automatic check_status(input tx_status_t got, input tx_status_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got len %0d addr %h, expected len %0d addr %h",
				$time, what, got.len, got.addr, exp.len, exp.addr);
		end
	endtask

	task automatic check_ar(input dram_ar_t got, input dram_ar_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got id %0d addr %h len %0d size %0d burst %0d, %s",
				$time, what, got.id, got.addr, got.len, got.size, got.burst,
				$sformatf("expected addr %h len %0d", exp.addr, exp.len));
		end
	endtask

`include "tx_frame_tests.svh"

	initial begin
		seed = 32'h9035_879d;
		errors = 0;
		ready_mode = READY_ALL;
		descs_sent = 0;
		beat_idx = 0;
		aresetn = 1'b0;
		cmd_s_tdata = '0;
		cmd_s_tvalid = 1'b0;
		cmd_s_tlast = 1'b0;
		stat_m_tready = 1'b1;
		mac_m_tready = 1'b1;
		dram_m_arready = 1'b1;
		dram_m_r = '0;
		dram_m_rvalid = 1'b0;
		repeat (2) @(posedge aclk);
		#1;
		aresetn = 1'b1;
		verify_reset_values();
		single_segment_frame();
		three_segment_frame();
		frame_gating();
		queue_full_release();
		mac_back_pressure();
		credit_limit();
		$display("Run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- tx_frame.f
+incdir+bench
hw/tx_frame_pkg.sv
hw/tx_desc_parser.sv
hw/tx_desc_queue.sv
hw/tx_dma_reader.sv
hw/tx_frame.sv
bench/tx_frame_tb.sv
